// ==== Makefile ====
# Verilator flow for the RV32I decode and execute slice.
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= rv_exec_slice_tb
FILELIST  ?= rv_exec_slice.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_STR  ?= \*\*\* TEST PASSED \*\*\*

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard source/*.sv source/*.svh verif/*.sv)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_STR)$$" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rv_exec_slice.f ====
+incdir+source
source/rv_pkg.sv
source/alu.sv
source/inst_decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/rv_exec_slice.sv
verif/rv_exec_slice_chk.sv
verif/rv_exec_slice_tb.sv

// ==== source/alu.sv ====
`timescale 1ns/1ns
`include "rv_slice_settings.svh"

module alu (
  input  rv_pkg::alu_op_t     op,
  input  [`RV_XLEN-1:0]       a,
  input  [`RV_XLEN-1:0]       b,
  output logic [`RV_XLEN-1:0] result
);
  import rv_pkg::*;

  localparam int SHW = $clog2(`RV_XLEN);

  logic [SHW-1:0] shamt;
  logic           lt_signed;
  logic           lt_unsigned;

  assign shamt       = b[SHW-1:0];  // Upper bits of b are ignored.
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb
  begin
    case (op)
      ALU_ADD:
        result = a + b;
      ALU_SUB:
        result = a - b;
      ALU_SLL:
        result = a << shamt;
      ALU_SLT:
        result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:
        result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:
        result = a ^ b;
      ALU_SRL:
        result = a >> shamt;
      ALU_SRA:
        result = $signed(a) >>> shamt;  // Sign bit fills.
      ALU_OR:
        result = a | b;
      ALU_AND:
        result = a & b;
      default:
        result = '0;
    endcase
  end

endmodule

// ==== source/exec_unit.sv ====
`timescale 1ns/1ns
`include "rv_slice_settings.svh"

module exec_unit (
  input                         clk,
  input                         rst,
  input                         inst_valid,
  input        [`RV_XLEN-1:0]   pc,
  input  rv_pkg::ex_unit_t      ex_unit,
  input  rv_pkg::alu_op_t       alu_op,
  input        [`RV_XLEN-1:0]   imm,
  input                         imm_en,
  input                         pc_en,
  input                         rd_en,
  input        [`RV_REG_AW-1:0] rd,
  input        [`RV_XLEN-1:0]   rs1_data,
  input        [`RV_XLEN-1:0]   rs2_data,
  output logic                  we,
  output logic [`RV_REG_AW-1:0] waddr,
  output logic [`RV_XLEN-1:0]   wdata,
  output logic                  wb_valid,
  output logic [`RV_REG_AW-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]   wb_data,
  output logic                  jump_valid,
  output logic [`RV_XLEN-1:0]   jump_target,
  output logic                  illegal
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] link;
  logic [`RV_XLEN-1:0] target_sum;
  logic [`RV_XLEN-1:0] target;

  assign op_a = pc_en ? pc : rs1_data;
  assign op_b = imm_en ? imm : rs2_data;

  alu alu_i (
    .op     (alu_op),
    .a      (op_a),
    .b      (op_b),
    .result (alu_result)
  );

  assign link       = pc + `RV_XLEN'(`RV_LINK_OFS);
  assign target_sum = op_a + imm;
  // JALR drops bit 0 of its sum; JAL keeps the pc relative sum.
  assign target     = pc_en ? target_sum : {target_sum[`RV_XLEN-1:1], 1'b0};

  always_comb
  begin
    case (ex_unit)
      EX_ALU:  wdata = alu_result;
      EX_FWD:  wdata = imm;
      EX_JUMP: wdata = link;
      default: wdata = '0;
    endcase
  end

  assign we    = inst_valid && rd_en && (ex_unit != EX_ERR);
  assign waddr = rd;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wb_valid   <= 1'b0;
      jump_valid <= 1'b0;
      illegal    <= 1'b0;
    end
    else
    begin
      wb_valid   <= we && (waddr != '0);  // x0 writes are silent.
      jump_valid <= inst_valid && (ex_unit == EX_JUMP);
      illegal    <= inst_valid && (ex_unit == EX_ERR);
    end
  end

  always_ff @(posedge clk)
  begin
    wb_rd       <= waddr;
    wb_data     <= wdata;
    jump_target <= target;
  end

endmodule

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ns
`include "rv_slice_settings.svh"

module inst_decoder (
  input  rv_pkg::inst_word_t      inst,
  output rv_pkg::ex_unit_t        ex_unit,
  output rv_pkg::alu_op_t         alu_op,
  output logic [`RV_XLEN-1:0]     imm,
  output logic                    imm_en,
  output logic                    pc_en,
  output logic [`RV_REG_AW-1:0]   rs1_addr,
  output logic [`RV_REG_AW-1:0]   rs2_addr,
  output logic                    rd_en,
  output logic [`RV_REG_AW-1:0]   rd
);
  import rv_pkg::*;

  // Merged {funct7, funct3} codes of the R-type operations.
  localparam logic [9:0] F73_ADD  = 10'b0000000_000;
  localparam logic [9:0] F73_SUB  = 10'b0100000_000;
  localparam logic [9:0] F73_SLL  = 10'b0000000_001;
  localparam logic [9:0] F73_SLT  = 10'b0000000_010;
  localparam logic [9:0] F73_SLTU = 10'b0000000_011;
  localparam logic [9:0] F73_XOR  = 10'b0000000_100;
  localparam logic [9:0] F73_SRL  = 10'b0000000_101;
  localparam logic [9:0] F73_SRA  = 10'b0100000_101;
  localparam logic [9:0] F73_OR   = 10'b0000000_110;
  localparam logic [9:0] F73_AND  = 10'b0000000_111;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  always_comb
  begin
    ex_unit  = EX_ERR;
    alu_op   = ALU_NOP;
    imm      = '0;
    imm_en   = 1'b0;
    pc_en    = 1'b0;
    rs1_addr = '0;
    rs2_addr = '0;
    rd_en    = 1'b0;
    rd       = '0;
    case (inst.r.opcode)
      `OPC_OP:
      begin
        case ({inst.r.funct7, inst.r.funct3})
          F73_ADD:  alu_op = ALU_ADD;
          F73_SUB:  alu_op = ALU_SUB;
          F73_SLL:  alu_op = ALU_SLL;
          F73_SLT:  alu_op = ALU_SLT;
          F73_SLTU: alu_op = ALU_SLTU;
          F73_XOR:  alu_op = ALU_XOR;
          F73_SRL:  alu_op = ALU_SRL;
          F73_SRA:  alu_op = ALU_SRA;
          F73_OR:   alu_op = ALU_OR;
          F73_AND:  alu_op = ALU_AND;
          default:  alu_op = ALU_NOP;
        endcase
        if (alu_op != ALU_NOP)
        begin
          ex_unit  = EX_ALU;
          rs1_addr = inst.r.rs1;
          rs2_addr = inst.r.rs2;
          rd_en    = 1'b1;
          rd       = inst.r.rd;
        end
      end
      `OPC_OP_IMM:
      begin
        imm = {{(`RV_XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
        case (inst.i.funct3)
          F3_ADD:  alu_op = ALU_ADD;
          F3_SLT:  alu_op = ALU_SLT;
          F3_SLTU: alu_op = ALU_SLTU;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          F3_SLL:
          begin
            if (inst.r.funct7 == F7_BASE)
              alu_op = ALU_SLL;
            imm = {{(`RV_XLEN-5){1'b0}}, inst.r.rs2};  // Shamt sits in the rs2 field.
          end
          F3_SR:
          begin
            if (inst.r.funct7 == F7_BASE)
              alu_op = ALU_SRL;
            else if (inst.r.funct7 == F7_ALT)
              alu_op = ALU_SRA;  // Bit 30 picks arithmetic.
            imm = {{(`RV_XLEN-5){1'b0}}, inst.r.rs2};
          end
          default: alu_op = ALU_NOP;
        endcase
        if (alu_op != ALU_NOP)
        begin
          ex_unit  = EX_ALU;
          imm_en   = 1'b1;
          rs1_addr = inst.i.rs1;
          rd_en    = 1'b1;
          rd       = inst.i.rd;
        end
        else
          imm = '0;
      end
      `OPC_LUI:
      begin
        ex_unit = EX_FWD;
        imm     = {inst[31:12], 12'b0};
        imm_en  = 1'b1;
        rd_en   = 1'b1;
        rd      = inst.r.rd;
      end
      `OPC_AUIPC:
      begin
        ex_unit = EX_ALU;
        alu_op  = ALU_ADD;
        imm     = {inst[31:12], 12'b0};
        imm_en  = 1'b1;
        pc_en   = 1'b1;
        rd_en   = 1'b1;
        rd      = inst.r.rd;
      end
      `OPC_JAL:
      begin
        ex_unit = EX_JUMP;
        imm     = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                   inst[30:21], 1'b0};
        imm_en  = 1'b1;
        pc_en   = 1'b1;  // Target is pc relative.
        rd_en   = 1'b1;
        rd      = inst.r.rd;
      end
      `OPC_JALR:
      begin
        if (inst.i.funct3 == F3_ADD)
        begin
          ex_unit  = EX_JUMP;
          imm      = {{(`RV_XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
          imm_en   = 1'b1;
          rs1_addr = inst.i.rs1;
          rd_en    = 1'b1;
          rd       = inst.i.rd;
        end
      end
      default: ex_unit = EX_ERR;
    endcase
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ns
`include "rv_slice_settings.svh"

module reg_file (
  input                         clk,
  input                         rst,
  input        [`RV_REG_AW-1:0] rs1_addr,
  input        [`RV_REG_AW-1:0] rs2_addr,
  input                         we,
  input        [`RV_REG_AW-1:0] waddr,
  input        [`RV_XLEN-1:0]   wdata,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);

  // x0 has no storage.
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 1; i < `RV_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (we && (waddr != '0))
    begin
      regs[waddr] <= wdata;
    end
  end

  // Reads see the value written at the previous edge.
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== source/rv_exec_slice.sv ====
`timescale 1ns/1ns
`include "rv_slice_settings.svh"

module rv_exec_slice (
  input                         clk,
  input                         rst,
  input                         inst_valid,
  input        [`RV_XLEN-1:0]   inst,
  input        [`RV_XLEN-1:0]   pc,
  output logic                  wb_valid,
  output logic [`RV_REG_AW-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]   wb_data,
  output logic                  jump_valid,
  output logic [`RV_XLEN-1:0]   jump_target,
  output logic                  illegal
);
  import rv_pkg::*;

  ex_unit_t              ex_unit;
  alu_op_t               alu_op;
  logic [`RV_XLEN-1:0]   imm;
  logic                  imm_en;
  logic                  pc_en;
  logic [`RV_REG_AW-1:0] rs1_addr;
  logic [`RV_REG_AW-1:0] rs2_addr;
  logic                  rd_en;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic                  we;
  logic [`RV_REG_AW-1:0] waddr;
  logic [`RV_XLEN-1:0]   wdata;

  inst_decoder decoder_i (
    .inst     (inst),
    .ex_unit  (ex_unit),
    .alu_op   (alu_op),
    .imm      (imm),
    .imm_en   (imm_en),
    .pc_en    (pc_en),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_en    (rd_en),
    .rd       (rd)
  );

  reg_file reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .we       (we),
    .waddr    (waddr),
    .wdata    (wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit exec_unit_i (
    .clk         (clk),
    .rst         (rst),
    .inst_valid  (inst_valid),
    .pc          (pc),
    .ex_unit     (ex_unit),
    .alu_op      (alu_op),
    .imm         (imm),
    .imm_en      (imm_en),
    .pc_en       (pc_en),
    .rd_en       (rd_en),
    .rd          (rd),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .we          (we),
    .waddr       (waddr),
    .wdata       (wdata),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .jump_valid  (jump_valid),
    .jump_target (jump_target),
    .illegal     (illegal)
  );

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

  // Unit that produces the write-back value.
  typedef enum logic [1:0] {
    EX_ALU  = 2'd0,
    EX_FWD  = 2'd1,  // Immediate passed through.
    EX_JUMP = 2'd2,
    EX_ERR  = 2'd3
  } ex_unit_t;

  typedef enum logic [3:0] {
    ALU_NOP  = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_SLL  = 4'd3,
    ALU_SLT  = 4'd4,
    ALU_SLTU = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_SRL  = 4'd7,
    ALU_SRA  = 4'd8,
    ALU_OR   = 4'd9,
    ALU_AND  = 4'd10
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // One instruction word seen in either format.
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_word_t;

endpackage

// ==== source/rv_slice_settings.svh ====
`ifndef RV_SLICE_SETTINGS_SVH
`define RV_SLICE_SETTINGS_SVH

// Datapath and register file geometry.
`define RV_XLEN      32
`define RV_REG_AW    5
`define RV_NUM_REGS  32

// Major opcodes in bits [6:0] of the instruction word.
`define OPC_OP       7'b0110011
`define OPC_OP_IMM   7'b0010011
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111

// Link offset written by JAL and JALR.
`define RV_LINK_OFS  4

`endif

// ==== verif/rv_exec_slice_chk.sv ====
`timescale 1ns/1ns
`include "rv_slice_settings.svh"

module rv_exec_slice_chk (
  input                        clk,
  input                        rst,
  input                        inst_valid,
  input                        wb_valid,
  input       [`RV_REG_AW-1:0] wb_rd,
  input                        jump_valid,
  input       [`RV_XLEN-1:0]   jump_target,
  input                        illegal
);

  logic any_strobe;

  assign any_strobe = wb_valid || jump_valid || illegal;

  strobes_low_after_reset: assert property (
    @(posedge clk) rst |=> !any_strobe
  ) else $error("output strobe high in the cycle after a reset edge");

  no_wb_to_x0: assert property (
    @(posedge clk) disable iff (rst) wb_valid |-> (wb_rd != '0)
  ) else $error("wb_valid reported for register x0");

  illegal_alone: assert property (
    @(posedge clk) disable iff (rst) illegal |-> !(wb_valid || jump_valid)
  ) else $error("illegal raised together with wb_valid or jump_valid");

  // Every outcome comes from an instruction strobed one cycle earlier.
  strobe_follows_valid: assert property (
    @(posedge clk) disable iff (rst) any_strobe |-> $past(inst_valid)
  ) else $error("output strobe without inst_valid in the previous cycle");

  jump_target_aligned: assert property (
    @(posedge clk) disable iff (rst) jump_valid |-> !jump_target[0]
  ) else $error("jump_target has bit 0 set");

endmodule

// ==== verif/rv_exec_slice_tb.sv ====
`timescale 1ns/1ns
`include "rv_slice_settings.svh"

module rv_exec_slice_tb;

  localparam int NUM_INST     = 2000;
  localparam int NUM_SWEEP    = `RV_NUM_REGS;
  localparam int RESET_CYCLES = 10;
  localparam int CYCLE_LIMIT  = 2 * (NUM_INST + NUM_SWEEP) + RESET_CYCLES;

  // Small register pool so that dependencies are frequent.
  localparam logic [39:0] REG_POOL = {5'd31, 5'd15, 5'd9, 5'd4, 5'd3, 5'd2, 5'd1, 5'd0};

  logic                  clk;
  logic                  rst;
  logic                  inst_valid;
  logic [`RV_XLEN-1:0]   inst;
  logic [`RV_XLEN-1:0]   pc;
  logic                  wb_valid;
  logic [`RV_REG_AW-1:0] wb_rd;
  logic [`RV_XLEN-1:0]   wb_data;
  logic                  jump_valid;
  logic [`RV_XLEN-1:0]   jump_target;
  logic                  illegal;

  logic [31:0]           lfsr;
  logic [`RV_XLEN-1:0]   model_regs [0:`RV_NUM_REGS-1];
  logic                  exp_wb;
  logic [`RV_REG_AW-1:0] exp_rd;
  logic [`RV_XLEN-1:0]   exp_data;
  logic                  exp_jump;
  logic [`RV_XLEN-1:0]   exp_target;
  logic                  exp_ill;
  int                    errors;
  int                    checks;
  int                    cycle_count;

  rv_exec_slice dut_i (
    .clk         (clk),
    .rst         (rst),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .pc          (pc),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .jump_valid  (jump_valid),
    .jump_target (jump_target),
    .illegal     (illegal)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic logic [4:0] pick_reg();
    logic [2:0] idx;
    idx = 3'(take_bits(3));
    return REG_POOL[int'(idx) * 5 +: 5];
  endfunction

  // RV32I integer operations selected by funct3 and instruction bit 30.
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // Encodings outside the supported subset.
  function automatic logic [31:0] illegal_word(input logic [1:0] kind, input logic [31:0] bits);
    logic [6:0] opc;
    case (bits[1:0])
      2'd0:    opc = 7'b0000011;  // Load.
      2'd1:    opc = 7'b0100011;  // Store.
      2'd2:    opc = 7'b1100011;  // Branch.
      default: opc = 7'b1110011;  // System.
    endcase
    case (kind)
      2'd0:    return {bits[31:7], opc};
      2'd1:    return {7'b0000001, bits[24:7], `OPC_OP};
      2'd2:    return bits[12] ? {7'b0000001, bits[24:15], 3'b101, bits[11:7], `OPC_OP_IMM}
                               : {7'b0100000, bits[24:15], 3'b001, bits[11:7], `OPC_OP_IMM};
      default: return {bits[31:15], bits[14:12] | 3'b001, bits[11:7], `OPC_JALR};
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    errors++;
    $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, want);
  endtask

  task automatic check_outputs();
    checks++;
    assert (wb_valid === exp_wb) else report_mismatch("wb_valid", 32'(wb_valid), 32'(exp_wb));
    assert (jump_valid === exp_jump)
    else report_mismatch("jump_valid", 32'(jump_valid), 32'(exp_jump));
    assert (illegal === exp_ill) else report_mismatch("illegal", 32'(illegal), 32'(exp_ill));
    if (exp_wb)
    begin
      assert (wb_rd === exp_rd) else report_mismatch("wb_rd", 32'(wb_rd), 32'(exp_rd));
      assert (wb_data === exp_data) else report_mismatch("wb_data", wb_data, exp_data);
    end
    if (exp_jump)
      assert (jump_target === exp_target) else report_mismatch("jump_target", jump_target,
                                                                 exp_target);
  endtask

  task automatic issue(input logic [31:0] word, input logic [31:0] pc_val, input logic writes,
                       input logic [4:0] rd, input logic [31:0] data, input logic jump,
                       input logic [31:0] target, input logic ill);
    inst_valid = 1'b1;
    inst       = word;
    pc         = pc_val;
    exp_wb     = writes && (rd != 5'd0);
    exp_rd     = rd;
    exp_data   = data;
    exp_jump   = jump;
    exp_target = target;
    exp_ill    = ill;
    if (exp_wb)
      model_regs[rd] = data;  // Written at the coming edge.
  endtask

  task automatic issue_random();
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [31:0] pc_val;
    logic [31:0] opb;
    logic [31:0] sum;
    kind   = 4'(take_bits(4));
    rd     = pick_reg();
    rs1    = pick_reg();
    rs2    = pick_reg();
    f3     = 3'(take_bits(3));
    alt    = 1'(take_bits(1));
    imm12  = 12'(take_bits(12));
    imm20  = 20'(take_bits(20));
    pc_val = {30'(take_bits(30)), 2'b00};
    case (kind)
      4'd0, 4'd1, 4'd2, 4'd3:
      begin
        alt = alt && ((f3 == 3'b000) || (f3 == 3'b101));
        issue({1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OPC_OP}, pc_val, 1'b1, rd,
              alu_model(f3, alt, model_regs[rs1], model_regs[rs2]), 1'b0, '0, 1'b0);
      end
      4'd4, 4'd5, 4'd6:
      begin
        if ((f3 == 3'b001) || (f3 == 3'b101))
        begin
          alt   = alt && (f3 == 3'b101);
          imm12 = {1'b0, alt, 5'b0, imm12[4:0]};  // Shamt form.
          opb   = {27'b0, imm12[4:0]};
        end
        else
        begin
          alt = 1'b0;
          opb = {{20{imm12[11]}}, imm12};
        end
        issue({imm12, rs1, f3, rd, `OPC_OP_IMM}, pc_val, 1'b1, rd,
              alu_model(f3, alt, model_regs[rs1], opb), 1'b0, '0, 1'b0);
      end
      4'd7:
        issue({imm20, rd, `OPC_LUI}, pc_val, 1'b1, rd, {imm20, 12'b0}, 1'b0, '0, 1'b0);
      4'd8:
        issue({imm20, rd, `OPC_AUIPC}, pc_val, 1'b1, rd, pc_val + {imm20, 12'b0},
              1'b0, '0, 1'b0);
      4'd9:
        issue({imm20[19], imm20[9:0], imm20[10], imm20[18:11], rd, `OPC_JAL}, pc_val, 1'b1,
              rd, pc_val + 32'd4, 1'b1, pc_val + {{11{imm20[19]}}, imm20, 1'b0}, 1'b0);
      4'd10:
      begin
        sum = model_regs[rs1] + {{20{imm12[11]}}, imm12};
        issue({imm12, rs1, 3'b000, rd, `OPC_JALR}, pc_val, 1'b1, rd, pc_val + 32'd4,
              1'b1, {sum[31:1], 1'b0}, 1'b0);
      end
      4'd11, 4'd12:
        issue(illegal_word(imm20[1:0], take_bits(32)), pc_val, 1'b0, rd, '0, 1'b0, '0, 1'b1);
      default:
      begin
        inst_valid = 1'b0;  // Idle cycle with a junk word on the bus.
        inst       = take_bits(32);
        pc         = pc_val;
        exp_wb     = 1'b0;
        exp_jump   = 1'b0;
        exp_ill    = 1'b0;
      end
    endcase
  endtask

  initial
  begin
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    exp_wb     = 1'b0;
    exp_rd     = '0;
    exp_data   = '0;
    exp_jump   = 1'b0;
    exp_target = '0;
    exp_ill    = 1'b0;
    lfsr       = 32'h5ba5;
    errors     = 0;
    checks     = 0;
    for (int r = 0; r < `RV_NUM_REGS; r++)
      model_regs[r] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < NUM_INST; n++)
    begin
      @(negedge clk);
      check_outputs();
      issue_random();
    end
    // Read back every register through ADDI rN, rN, 0.
    for (int r = 0; r < NUM_SWEEP; r++)
    begin
      @(negedge clk);
      check_outputs();
      issue({12'd0, 5'(r), 3'b000, 5'(r), `OPC_OP_IMM}, 32'h0000_1000, 1'b1, 5'(r),
            model_regs[r], 1'b0, '0, 1'b0);
    end
    @(negedge clk);
    check_outputs();
    inst_valid = 1'b0;
    $display("Checked %0d cycles, %0d errors", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

bind rv_exec_slice rv_exec_slice_chk chk_i (
  .clk         (clk),
  .rst         (rst),
  .inst_valid  (inst_valid),
  .wb_valid    (wb_valid),
  .wb_rd       (wb_rd),
  .jump_valid  (jump_valid),
  .jump_target (jump_target),
  .illegal     (illegal)
);
